//--- rooth_defines.svh
/*
 * shared widths and codes; flow code 2'b11 is unused and never issued
 * bubble word is addi x0,x0,0 so it decodes as no branch and no jump
 */
`ifndef ROOTH_DEFINES_SVH
`define ROOTH_DEFINES_SVH

// ----------------------------------------------------------------------
// widths and reset values
// ----------------------------------------------------------------------
`define CPU_WIDTH       32
`define INST_WIDTH      32
`define WIDTH_BRANCH    3
`define WIDTH_JUMP      2
`define FLOW_WIDTH      2
`define RESET_PC        32'h0000_0000
`define INST_NOP        32'h0000_0013   // addi x0, x0, 0

// ----------------------------------------------------------------------
// rv32i opcodes seen by the decoder
// ----------------------------------------------------------------------
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_FENCE       7'b0001111

// branch types, zero means none
`define BRANCH_NONE     3'd0
`define BRANCH_BEQ      3'd1
`define BRANCH_BNE      3'd2
`define BRANCH_BLT      3'd3
`define BRANCH_BGE      3'd4
`define BRANCH_BLTU     3'd5
`define BRANCH_BGEU     3'd6

// jump types, zero means none
`define JUMP_NONE       2'd0
`define JUMP_JAL        2'd1
`define JUMP_JALR       2'd2
`define JUMP_FENCE      2'd3

// per-stage flow codes
`define FLOW_WORK       2'b00   // load
`define FLOW_STOP       2'b01   // hold
`define FLOW_REFRESH    2'b10   // clear to bubble

`endif

//--- rooth_pkg.sv
/*
 * vector types shared by the control path and its testbench
 * widths follow rooth_defines.svh
 */
`default_nettype none

`include "rooth_defines.svh"

package rooth_pkg;

    // ------------------------------------------------------------------
    // data path words
    // ------------------------------------------------------------------
    typedef logic [`CPU_WIDTH-1:0]    cpu_word_t;   // pc, imm, operands
    typedef logic [`INST_WIDTH-1:0]   inst_t;

    // ------------------------------------------------------------------
    // control codes, values are the `define constants
    // ------------------------------------------------------------------
    typedef logic [`WIDTH_BRANCH-1:0] branch_t;     // BRANCH_*
    typedef logic [`WIDTH_JUMP-1:0]   jump_t;       // JUMP_*
    typedef logic [`FLOW_WIDTH-1:0]   flow_t;       // FLOW_*

endpackage

`default_nettype wire

//--- rooth_ctrl_if.sv
/*
 * decode-stage fields toward execute and the pipeline controller
 * all fields are combinational from the decode register
 */
`timescale 1ns/1ps
`default_nettype none

interface rooth_ctrl_if;
    import rooth_pkg::*;

    cpu_word_t pc;          // pc of the instruction in decode
    branch_t   branch;
    jump_t     jump;
    cpu_word_t imm;
    cpu_word_t rs1_data;
    cpu_word_t rs2_data;

    modport dec (output pc, branch, jump, imm, rs1_data, rs2_data);
    modport exe (input branch, rs1_data, rs2_data);
    modport ctl (input pc, branch, jump, imm, rs1_data);

endinterface

`default_nettype wire

//--- rooth_pc_reg.sv
/*
 * fetch pc, loads only on FLOW_WORK; STOP and REFRESH both hold
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module rooth_pc_reg (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  rooth_pkg::flow_t    flow_pc_i,
    input  rooth_pkg::cpu_word_t next_pc_i,
    input  wire                 next_pc_four_i,  // take pc + 4 instead of next_pc_i
    output rooth_pkg::cpu_word_t pc_o
);
    import rooth_pkg::*;

    cpu_word_t pc_q;
    cpu_word_t pc_four;

    assign pc_four = pc_q + `CPU_WIDTH'd4;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else if (flow_pc_i == `FLOW_WORK) begin
            pc_q <= next_pc_four_i ? pc_four : next_pc_i;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- rooth_branch_decode.sv
/*
 * decode register plus branch and jump decoder
 * operands come straight from the register file for the word in decode
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module rooth_branch_decode (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  rooth_pkg::flow_t     flow_de_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  rooth_pkg::inst_t     inst_i,
    input  rooth_pkg::cpu_word_t rs1_data_i,
    input  rooth_pkg::cpu_word_t rs2_data_i,
    rooth_ctrl_if.dec            ctrl
);
    import rooth_pkg::*;

    cpu_word_t  pc_q;
    inst_t      inst_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    branch_t    branch;
    jump_t      jump;
    cpu_word_t  imm;

    // ------------------------------------------------------------------
    // decode-stage register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            inst_q <= `INST_NOP;            // bubble after reset
        end else begin
            case (flow_de_i)
                `FLOW_WORK:    inst_q <= inst_i;
                `FLOW_REFRESH: inst_q <= `INST_NOP;
                default:       inst_q <= inst_q;   // stop
            endcase
        end
    end

    // pc only matters when the word is a branch or jump
    always_ff @(posedge clk_i) begin
        if (flow_de_i == `FLOW_WORK) begin
            pc_q <= pc_i;
        end
    end

    // ------------------------------------------------------------------
    // branch, jump and immediate decode
    // ------------------------------------------------------------------
    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];

    always_comb begin
        branch = `BRANCH_NONE;
        jump   = `JUMP_NONE;
        imm    = {{21{inst_q[31]}}, inst_q[30:20]};     // I-type by default
        case (opcode)
            `OPC_BRANCH: begin
                imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
                case (funct3)
                    3'b000:  branch = `BRANCH_BEQ;
                    3'b001:  branch = `BRANCH_BNE;
                    3'b100:  branch = `BRANCH_BLT;
                    3'b101:  branch = `BRANCH_BGE;
                    3'b110:  branch = `BRANCH_BLTU;
                    3'b111:  branch = `BRANCH_BGEU;
                    default: branch = `BRANCH_NONE;  // reserved funct3
                endcase
            end
            `OPC_JAL: begin
                jump = `JUMP_JAL;
                imm  = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
            end
            `OPC_JALR: begin
                jump = `JUMP_JALR;              // keeps the I-type imm
            end
            `OPC_FENCE: begin
                jump = `JUMP_FENCE;
                imm  = '0;                      // target is pc + 4, imm unused
            end
            default: begin
                branch = `BRANCH_NONE;
            end
        endcase
    end

    assign ctrl.pc       = pc_q;
    assign ctrl.branch   = branch;
    assign ctrl.jump     = jump;
    assign ctrl.imm      = imm;
    assign ctrl.rs1_data = rs1_data_i;
    assign ctrl.rs2_data = rs2_data_i;

endmodule

`default_nettype wire

//--- rooth_branch_compare.sv
/*
 * execute-stage branch comparator, purely combinational
 * less is signed for BLT/BGE, unsigned for every other type
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module rooth_branch_compare (
    rooth_ctrl_if.exe ctrl,
    output logic      zero_o,
    output logic      less_o,
    output logic      more_zero_o
);
    import rooth_pkg::*;

    logic signed_cmp;
    logic less_s;
    logic less_u;

    assign signed_cmp = (ctrl.branch == `BRANCH_BLT) || (ctrl.branch == `BRANCH_BGE);

    assign less_s = $signed(ctrl.rs1_data) < $signed(ctrl.rs2_data);
    assign less_u = ctrl.rs1_data < ctrl.rs2_data;

    assign zero_o      = (ctrl.rs1_data == ctrl.rs2_data);
    assign less_o      = signed_cmp ? less_s : less_u;
    assign more_zero_o = ~less_o;       // greater or equal

endmodule

`default_nettype wire

//--- rooth_pipeline_ctrl.sv
/*
 * pipeline flow controller; first matching condition wins
 * order: int, clint hold, mem hold, flow wait, imem, div, bus, branch, jump, halt
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module rooth_pipeline_ctrl (
    rooth_ctrl_if.ctl            ctrl,
    input  wire                  zero_i,
    input  wire                  less_i,
    input  wire                  more_zero_i,
    input  wire                  jtag_halt_i,
    input  wire                  clint_hold_i,
    input  wire                  clint_int_assert_i,
    input  rooth_pkg::cpu_word_t clint_int_addr_i,
    input  wire                  access_mem_hold_i,
    input  wire                  flow_wait_i,
    input  wire                  imem_access_i,
    input  wire                  alu_busy_i,     // divider busy
    input  wire                  bus_wait_i,
    output rooth_pkg::cpu_word_t next_pc_o,
    output logic                 next_pc_four_o,
    output rooth_pkg::flow_t     flow_pc_o,
    output rooth_pkg::flow_t     flow_de_o,
    output rooth_pkg::flow_t     flow_ex_o,
    output rooth_pkg::flow_t     flow_as_o,
    output rooth_pkg::flow_t     flow_wb_o
);
    import rooth_pkg::*;

    logic      taken;
    cpu_word_t pc_imm;

    assign pc_imm = ctrl.pc + ctrl.imm;

    // ------------------------------------------------------------------
    // branch condition from comparator flags
    // ------------------------------------------------------------------
    always_comb begin
        case (ctrl.branch)
            `BRANCH_BEQ:  taken = zero_i;
            `BRANCH_BNE:  taken = ~zero_i;
            `BRANCH_BLT,
            `BRANCH_BLTU: taken = less_i;
            `BRANCH_BGE,
            `BRANCH_BGEU: taken = more_zero_i;
            default:      taken = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // prioritized flow codes, listed as pc de ex as wb
    // ------------------------------------------------------------------
    always_comb begin
        next_pc_o      = '0;
        next_pc_four_o = 1'b0;
        {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
            {`FLOW_WORK, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK};

        if (clint_int_assert_i) begin
            next_pc_o = clint_int_addr_i;       // trap entry, flush all
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_WORK, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_REFRESH};
        end else if (clint_hold_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP};
        end else if (access_mem_hold_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH};
        end else if (flow_wait_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK};
        end else if (imem_access_i) begin
            // load/store to instruction memory steals the fetch port
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK};
        end else if (alu_busy_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK};
        end else if (bus_wait_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK};
        end else if (ctrl.branch != `BRANCH_NONE) begin
            if (taken) begin
                next_pc_o = pc_imm;
                flow_de_o = `FLOW_REFRESH;      // drop the wrong-path fetch
                flow_ex_o = `FLOW_REFRESH;
            end else begin
                next_pc_four_o = 1'b1;
            end
        end else if (ctrl.jump != `JUMP_NONE) begin
            flow_de_o = `FLOW_REFRESH;
            flow_ex_o = `FLOW_REFRESH;
            case (ctrl.jump)
                `JUMP_JAL:   next_pc_o = pc_imm;
                `JUMP_JALR:  next_pc_o = ctrl.rs1_data + ctrl.imm;
                default:     next_pc_o = ctrl.pc + `CPU_WIDTH'd4;   // fence refetch
            endcase
        end else if (jtag_halt_i) begin
            {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} =
                {`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP};
        end else begin
            next_pc_four_o = 1'b1;              // plain sequential fetch
        end
    end

endmodule

`default_nettype wire

//--- rooth_flow_top.sv
/*
 * control path top; instruction memory, register file and hold sources are external
 * inst_i must return the word at pc_o in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

module rooth_flow_top (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  rooth_pkg::inst_t     inst_i,
    input  rooth_pkg::cpu_word_t rs1_data_i,   // operands of the word in decode
    input  rooth_pkg::cpu_word_t rs2_data_i,
    input  wire                  jtag_halt_i,
    input  wire                  clint_hold_i,
    input  wire                  clint_int_assert_i,
    input  rooth_pkg::cpu_word_t clint_int_addr_i,
    input  wire                  access_mem_hold_i,
    input  wire                  flow_wait_i,
    input  wire                  imem_access_i,
    input  wire                  alu_busy_i,
    input  wire                  bus_wait_i,
    output rooth_pkg::cpu_word_t pc_o,
    output rooth_pkg::flow_t     flow_de_o,
    output rooth_pkg::flow_t     flow_ex_o,
    output rooth_pkg::flow_t     flow_as_o,
    output rooth_pkg::flow_t     flow_wb_o
);
    import rooth_pkg::*;

    cpu_word_t next_pc;
    logic      next_pc_four;
    flow_t     flow_pc;
    logic      zero;
    logic      less;
    logic      more_zero;

    rooth_ctrl_if ctrl_bus ();

    // ------------------------------------------------------------------
    // fetch and decode
    // ------------------------------------------------------------------
    rooth_pc_reg i_pc_reg (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flow_pc_i      (flow_pc),
        .next_pc_i      (next_pc),
        .next_pc_four_i (next_pc_four),
        .pc_o           (pc_o)
    );

    rooth_branch_decode i_branch_decode (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flow_de_i  (flow_de_o),
        .pc_i       (pc_o),
        .inst_i     (inst_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ctrl       (ctrl_bus.dec)
    );

    // ------------------------------------------------------------------
    // execute compare and flow control
    // ------------------------------------------------------------------
    rooth_branch_compare i_branch_compare (
        .ctrl        (ctrl_bus.exe),
        .zero_o      (zero),
        .less_o      (less),
        .more_zero_o (more_zero)
    );

    rooth_pipeline_ctrl i_pipeline_ctrl (
        .ctrl               (ctrl_bus.ctl),
        .zero_i             (zero),
        .less_i             (less),
        .more_zero_i        (more_zero),
        .jtag_halt_i        (jtag_halt_i),
        .clint_hold_i       (clint_hold_i),
        .clint_int_assert_i (clint_int_assert_i),
        .clint_int_addr_i   (clint_int_addr_i),
        .access_mem_hold_i  (access_mem_hold_i),
        .flow_wait_i        (flow_wait_i),
        .imem_access_i      (imem_access_i),
        .alu_busy_i         (alu_busy_i),
        .bus_wait_i         (bus_wait_i),
        .next_pc_o          (next_pc),
        .next_pc_four_o     (next_pc_four),
        .flow_pc_o          (flow_pc),
        .flow_de_o          (flow_de_o),
        .flow_ex_o          (flow_ex_o),
        .flow_as_o          (flow_as_o),
        .flow_wb_o          (flow_wb_o)
    );

endmodule

`default_nettype wire

//--- rooth_flow_asserts.sv
/*
 * assertions bound into rooth_pipeline_ctrl
 * clock, reset and fetch pc come from the sibling i_pc_reg in the top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module rooth_flow_asserts (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  rooth_pkg::cpu_word_t pc_i,
    input  rooth_pkg::flow_t     flow_pc_i,
    input  rooth_pkg::flow_t     flow_de_i,
    input  rooth_pkg::flow_t     flow_ex_i,
    input  rooth_pkg::flow_t     flow_as_i,
    input  rooth_pkg::flow_t     flow_wb_i,
    input  wire                  int_assert_i,
    input  rooth_pkg::cpu_word_t int_addr_i
);
    import rooth_pkg::*;

    // fetch pc frozen for one edge per STOP
    a_pc_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (flow_pc_i == `FLOW_STOP) |=> (pc_i == $past(pc_i)))
        else $error("pc changed while flow_pc was STOP");

    // trap entry clears decode and the fetch pc lands on the handler
    a_int_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        int_assert_i |-> (flow_de_i == `FLOW_REFRESH) ##1 (pc_i == $past(int_addr_i)))
        else $error("interrupt did not clear decode or redirect the pc");

    // 2'b11 is the unused flow code
    a_flow_legal: assert property (@(posedge clk_i) disable iff (rst_i)
        (flow_pc_i != 2'b11) && (flow_de_i != 2'b11) && (flow_ex_i != 2'b11)
        && (flow_as_i != 2'b11) && (flow_wb_i != 2'b11))
        else $error("flow code took the unused value");

endmodule

bind rooth_pipeline_ctrl rooth_flow_asserts i_flow_asserts (
    .clk_i        (i_pc_reg.clk_i),     // upward reference into rooth_flow_top
    .rst_i        (i_pc_reg.rst_i),
    .pc_i         (i_pc_reg.pc_o),
    .flow_pc_i    (flow_pc_o),
    .flow_de_i    (flow_de_o),
    .flow_ex_i    (flow_ex_o),
    .flow_as_i    (flow_as_o),
    .flow_wb_i    (flow_wb_o),
    .int_assert_i (clint_int_assert_i),
    .int_addr_i   (clint_int_addr_i)
);

`default_nettype wire

//--- tb_rooth_flow.sv
/*
 * testbench for rooth_flow_top, acting as instruction memory, register file and hold sources
 * imem is 64 words indexed by pc bits 7:2; every test starts from a reset
 */
`timescale 1ns/1ps
`default_nettype none

`include "rooth_defines.svh"

module tb_rooth_flow;
    import rooth_pkg::*;

    localparam int TEST_CYCLES = 400;
    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + 600;   // resets plus slack
    localparam int MODE_NONE   = 0;
    localparam int MODE_HOLD   = 1;
    localparam int MODE_INT    = 2;

    logic        clk;
    logic        rst;
    inst_t       inst;
    cpu_word_t   rs1_data;
    cpu_word_t   rs2_data;
    logic [7:0]  holds;       // int, clint, mem, flow wait, imem, alu, bus, halt
    cpu_word_t   int_addr;
    cpu_word_t   pc;
    flow_t       flow_de;
    flow_t       flow_ex;
    flow_t       flow_as;
    flow_t       flow_wb;

    inst_t       imem        [64];
    branch_t     meta_branch [64];   // what each word should decode to
    jump_t       meta_jump   [64];
    cpu_word_t   meta_imm    [64];

    cpu_word_t   m_pc;
    cpu_word_t   m_de_pc;
    logic        m_de_valid;
    flow_t       e_flow      [5];    // pc de ex as wb
    cpu_word_t   e_target;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;
    int unsigned seed;

    assign inst = imem[pc[7:2]];    // combinational fetch

    rooth_flow_top i_dut (
        .clk_i              (clk),
        .rst_i              (rst),
        .inst_i             (inst),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .jtag_halt_i        (holds[7]),
        .clint_hold_i       (holds[1]),
        .clint_int_assert_i (holds[0]),
        .clint_int_addr_i   (int_addr),
        .access_mem_hold_i  (holds[2]),
        .flow_wait_i        (holds[3]),
        .imem_access_i      (holds[4]),
        .alu_busy_i         (holds[5]),
        .bus_wait_i         (holds[6]),
        .pc_o               (pc),
        .flow_de_o          (flow_de),
        .flow_ex_o          (flow_ex),
        .flow_as_o          (flow_as),
        .flow_wb_o          (flow_wb)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing the tests", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_pc(input cpu_word_t got, input cpu_word_t exp);
        if (got !== exp) begin
            $display("FAILED %0t pc_o is %h, expected %h", $time, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_flow(input flow_t got, input flow_t exp, input string stage);
        if (got !== exp) begin
            $display("FAILED %0t flow_%s is %b, expected %b", $time, stage, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // ------------------------------------------------------------------
    // program generation and reset
    // ------------------------------------------------------------------
    task automatic fill_imem(input int pct_branch, input int pct_jump);
        int          roll;
        int          k;
        cpu_word_t   imm;
        logic [2:0]  f3;
        logic [11:0] alu_imm;
        for (int i = 0; i < 64; i++) begin
            roll           = $urandom_range(99);
            imm            = ($urandom_range(32) - 16) * 4;   // -64 .. +64, word aligned
            alu_imm        = $urandom_range(4095);
            meta_branch[i] = `BRANCH_NONE;
            meta_jump[i]   = `JUMP_NONE;
            meta_imm[i]    = imm;
            imem[i]        = {alu_imm, 5'd3, 3'b000, 5'd3, 7'b0010011};   // addi
            if (roll < pct_branch) begin
                k = $urandom_range(5);
                case (k)
                    0: begin
                        f3             = 3'b000;
                        meta_branch[i] = `BRANCH_BEQ;
                    end
                    1: begin
                        f3             = 3'b001;
                        meta_branch[i] = `BRANCH_BNE;
                    end
                    2: begin
                        f3             = 3'b100;
                        meta_branch[i] = `BRANCH_BLT;
                    end
                    3: begin
                        f3             = 3'b101;
                        meta_branch[i] = `BRANCH_BGE;
                    end
                    4: begin
                        f3             = 3'b110;
                        meta_branch[i] = `BRANCH_BLTU;
                    end
                    default: begin
                        f3             = 3'b111;
                        meta_branch[i] = `BRANCH_BGEU;
                    end
                endcase
                imem[i] = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
            end else if (roll < pct_branch + pct_jump) begin
                k = $urandom_range(2);
                if (k == 0) begin
                    meta_jump[i] = `JUMP_JAL;
                    imem[i] = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OPC_JAL};
                end else if (k == 1) begin
                    meta_jump[i] = `JUMP_JALR;
                    imem[i] = {imm[11:0], 5'd1, 3'b000, 5'd1, `OPC_JALR};
                end else begin
                    meta_jump[i] = `JUMP_FENCE;
                    imem[i] = 32'h0ff0_000f;
                end
            end
        end
    endtask

    task automatic reset_dut(input int pct_branch, input int pct_jump);
        rst      = 1'b1;
        holds    = '0;
        rs1_data = '0;
        rs2_data = '0;
        fill_imem(pct_branch, pct_jump);
        repeat (3) @(posedge clk);
        #2;
        rst        = 1'b0;
        m_pc       = `RESET_PC;
        m_de_valid = 1'b0;       // decode starts as a bubble
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    task automatic drive_inputs(input int mode, input int cyc);
        jump_t jp;
        jp       = m_de_valid ? meta_jump[m_de_pc[7:2]] : `JUMP_NONE;
        rs1_data = $urandom();
        rs2_data = ($urandom_range(3) == 0) ? rs1_data : $urandom();
        if (jp == `JUMP_JALR) begin
            rs1_data = $urandom_range(63) * 4;   // aligned jalr base
        end
        int_addr = $urandom_range(63) * 4;
        holds    = '0;
        if (mode == MODE_HOLD && cyc < 140) begin
            holds[cyc / 20 + 1] = $urandom_range(1);   // one hold input at a time
        end else if (mode == MODE_HOLD) begin
            for (int b = 1; b < 8; b++) holds[b] = ($urandom_range(5) == 0);
        end else if (mode == MODE_INT) begin
            for (int b = 1; b < 8; b++) holds[b] = ($urandom_range(7) == 0);
            holds[0] = ($urandom_range(9) == 0);
        end
    endtask

    task automatic set_expected(input flow_t f_pc, input flow_t f_de, input flow_t f_ex,
                                input flow_t f_as, input flow_t f_wb);
        e_flow[0] = f_pc;
        e_flow[1] = f_de;
        e_flow[2] = f_ex;
        e_flow[3] = f_as;
        e_flow[4] = f_wb;
    endtask

    task automatic predict();
        branch_t   br;
        jump_t     jp;
        cpu_word_t imm;
        logic      taken;
        br  = m_de_valid ? meta_branch[m_de_pc[7:2]] : `BRANCH_NONE;
        jp  = m_de_valid ? meta_jump[m_de_pc[7:2]] : `JUMP_NONE;
        imm = m_de_valid ? meta_imm[m_de_pc[7:2]] : '0;
        case (br)
            `BRANCH_BEQ:  taken = (rs1_data == rs2_data);
            `BRANCH_BNE:  taken = (rs1_data != rs2_data);
            `BRANCH_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            `BRANCH_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            `BRANCH_BLTU: taken = (rs1_data < rs2_data);
            `BRANCH_BGEU: taken = (rs1_data >= rs2_data);
            default:      taken = 1'b0;
        endcase
        e_target = m_pc + 4;
        set_expected(`FLOW_WORK, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK);
        if (holds[0]) begin
            set_expected(`FLOW_WORK, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_REFRESH);
            e_target = int_addr;
        end else if (holds[1]) begin
            set_expected(`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP);
        end else if (holds[2]) begin
            set_expected(`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH);
        end else if (holds[3] || (!holds[4] && holds[5])) begin   // flow wait, alu busy
            set_expected(`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK);
        end else if (holds[4]) begin
            set_expected(`FLOW_STOP, `FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK);
        end else if (holds[6]) begin
            set_expected(`FLOW_STOP, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK, `FLOW_WORK);
        end else if (br != `BRANCH_NONE) begin
            if (taken) begin
                set_expected(`FLOW_WORK, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK);
                e_target = m_de_pc + imm;
            end
        end else if (jp != `JUMP_NONE) begin
            set_expected(`FLOW_WORK, `FLOW_REFRESH, `FLOW_REFRESH, `FLOW_WORK, `FLOW_WORK);
            if (jp == `JUMP_JAL) e_target = m_de_pc + imm;
            else if (jp == `JUMP_JALR) e_target = rs1_data + imm;
            else e_target = m_de_pc + 4;
        end else if (holds[7]) begin
            set_expected(`FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP, `FLOW_STOP);
        end
    endtask

    task automatic advance_model();
        cpu_word_t fetch_pc;
        fetch_pc = m_pc;
        if (e_flow[0] == `FLOW_WORK) m_pc = e_target;
        if (e_flow[1] == `FLOW_WORK) begin
            m_de_valid = 1'b1;
            m_de_pc    = fetch_pc;
        end else if (e_flow[1] == `FLOW_REFRESH) begin
            m_de_valid = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic run_cycle(input int mode, input int cyc);
        drive_inputs(mode, cyc);
        @(negedge clk);                 // flows settled
        predict();
        check_flow(flow_de, e_flow[1], "de");
        check_flow(flow_ex, e_flow[2], "ex");
        check_flow(flow_as, e_flow[3], "as");
        check_flow(flow_wb, e_flow[4], "wb");
        @(posedge clk);
        #2;
        advance_model();
        check_pc(pc, m_pc);
    endtask

    task automatic run_test(input string name, input int mode, input int pct_b, input int pct_j);
        int p0;
        int f0;
        p0 = pass_count;
        f0 = fail_count;
        reset_dut(pct_b, pct_j);
        for (int c = 0; c < TEST_CYCLES; c++) run_cycle(mode, c);
        $display("test %-10s %0d passed, %0d failed", name, pass_count - p0, fail_count - f0);
    endtask

    task automatic test_reset();
        int p0;
        int f0;
        p0 = pass_count;
        f0 = fail_count;
        reset_dut(0, 0);
        check_pc(pc, `RESET_PC);
        @(negedge clk);
        check_flow(flow_de, `FLOW_WORK, "de");
        check_flow(flow_ex, `FLOW_WORK, "ex");
        check_flow(flow_as, `FLOW_WORK, "as");
        check_flow(flow_wb, `FLOW_WORK, "wb");
        @(posedge clk);
        #2;
        $display("test %-10s %0d passed, %0d failed", "reset", pass_count - p0, fail_count - f0);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        holds      = '0;
        rs1_data   = '0;
        rs2_data   = '0;
        int_addr   = '0;
        pass_count = 0;
        fail_count = 0;
        seed       = $urandom(66);
        test_reset();
        run_test("sequential", MODE_NONE, 0, 0);
        run_test("branches", MODE_NONE, 50, 0);
        run_test("jumps", MODE_NONE, 0, 40);
        run_test("holds", MODE_HOLD, 25, 20);
        run_test("interrupt", MODE_INT, 25, 20);
        $display("total %0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
rooth_pkg.sv
rooth_ctrl_if.sv
rooth_pc_reg.sv
rooth_branch_decode.sv
rooth_branch_compare.sv
rooth_pipeline_ctrl.sv
rooth_flow_top.sv
rooth_flow_asserts.sv
tb_rooth_flow.sv

//--- Bender.yml
package:
  name: rooth_flow

sources:
  - include_dirs:
      - .
    files:
      - rooth_pkg.sv
      - rooth_ctrl_if.sv
      - rooth_pc_reg.sv
      - rooth_branch_decode.sv
      - rooth_branch_compare.sv
      - rooth_pipeline_ctrl.sv
      - rooth_flow_top.sv
      - target: test
        files:
          - rooth_flow_asserts.sv
          - tb_rooth_flow.sv
